// ==== Makefile ====
# Verilator build and run of the capture engine testbench

VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := scope_capture_tb
FILELIST  := sim.f
BUILD_DIR := obj_dir
PASS_TEXT := Test completed successfully

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard design/*.svh)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@output="$$($(SIM_BIN))"; \
	echo "$$output"; \
	echo "$$output" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// ==== design/capture_buffer.sv ====
// Circular pre/post-trigger window, single rising-edge trigger on one channel
// A frame is always FRAME_DEPTH entries and is held until rearm

`include "scope_macros.svh"

module capture_buffer (
    input  logic clock,
    input  logic reset,
    input  scope_pkg::sample_t in_sample,
    input  logic in_valid,
    output logic in_ready,
    input  scope_pkg::trigger_cfg_t trigger,
    output scope_pkg::sample_t frame_sample,
    output logic frame_valid,
    output logic frame_last,
    input  logic frame_ready,
    input  logic rearm
);

    localparam int DEPTH = `SCOPE_FRAME_DEPTH;
    localparam int ADDR_W = $clog2(DEPTH);

    typedef enum logic [1:0] {
        ARMING,
        FILLING,
        READOUT
    } state_t;

    state_t state;
    scope_pkg::sample_t storage [DEPTH];
    logic [ADDR_W-1:0] wr_ptr;
    logic [ADDR_W-1:0] rd_idx;
    logic [ADDR_W:0] fill_count;
    logic [ADDR_W-1:0] post_left;
    logic [ADDR_W-1:0] post_total;
    logic [`SCOPE_SAMPLE_WIDTH-1:0] prev_data;
    logic drained;
    logic accept;
    logic on_channel;
    logic crossing;
    logic hit;

    assign in_ready = state != READOUT;
    assign accept = in_valid && in_ready;

    // Rising crossing, checked against the last value seen on the trigger channel
    assign on_channel = in_sample.channel == trigger.channel;
    assign crossing = on_channel && (in_sample.data > trigger.level)
                      && !(prev_data > trigger.level);
    assign hit = accept && (state == ARMING) && crossing
                 && (fill_count >= {1'b0, trigger.point});

    // Entries still to come after the trigger sample
    assign post_total = ADDR_W'(DEPTH - 1) - trigger.point;

    always_ff @(posedge clock) begin
        if (accept) begin
            storage[wr_ptr] <= in_sample;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state      <= ARMING;
            wr_ptr     <= '0;
            rd_idx     <= '0;
            fill_count <= '0;
            post_left  <= '0;
            prev_data  <= '0;
            drained    <= 1'b0;
        end else if (rearm) begin
            state      <= ARMING;
            rd_idx     <= '0;
            fill_count <= '0;
            post_left  <= '0;
            prev_data  <= '0;
            drained    <= 1'b0;
        end else begin
            case (state)
                ARMING: begin
                    if (accept) begin
                        wr_ptr <= wr_ptr + 1'b1;
                        if (fill_count != (ADDR_W+1)'(DEPTH)) fill_count <= fill_count + 1'b1;
                        if (on_channel) prev_data <= in_sample.data;
                    end
                    if (hit) begin
                        post_left <= post_total;
                        state <= (post_total == '0) ? READOUT : FILLING;
                    end
                end
                FILLING: begin
                    if (accept) begin
                        wr_ptr <= wr_ptr + 1'b1;
                        post_left <= post_left - 1'b1;
                        if (post_left == ADDR_W'(1)) state <= READOUT;
                    end
                end
                default: begin
                    if (frame_valid && frame_ready) begin
                        rd_idx <= rd_idx + 1'b1;
                        if (frame_last) drained <= 1'b1;
                    end
                end
            endcase
        end
    end

    // Oldest entry sits at the next write slot once the window is full
    assign frame_sample = storage[wr_ptr + rd_idx];
    assign frame_valid  = (state == READOUT) && !drained;
    assign frame_last   = rd_idx == ADDR_W'(DEPTH - 1);

    // The frozen window is never overwritten while it is held
    assert property (@(posedge clock) disable iff (reset)
        state == READOUT && !rearm |=> $stable(wr_ptr));

endmodule

// ==== design/channel_arbiter.sv ====
// Round-robin merge of the input streams, grant is combinational
// Channel 0 has first turn after reset

`include "scope_macros.svh"

module channel_arbiter (
    input  logic clock,
    input  logic reset,
    input  logic [`SCOPE_SAMPLE_WIDTH-1:0] sample_data [`SCOPE_N_CHANNELS],
    input  logic [`SCOPE_N_CHANNELS-1:0] sample_valid,
    output logic [`SCOPE_N_CHANNELS-1:0] sample_ready,
    output scope_pkg::sample_t out_sample,
    output logic out_valid,
    input  logic out_ready
);

    localparam int N = `SCOPE_N_CHANNELS;
    localparam int CH_W = `SCOPE_CHANNEL_BITS;

    logic [CH_W-1:0] last;
    logic [CH_W-1:0] grant;
    logic found;

    // Search starts one past the previous winner
    always_comb begin
        int idx;
        found = 1'b0;
        grant = '0;
        for (int k = 1; k <= N; k++) begin
            idx = (int'(last) + k) % N;
            if (!found && sample_valid[idx]) begin
                found = 1'b1;
                grant = CH_W'(idx);
            end
        end
    end

    assign out_valid = found;
    assign out_sample.channel = grant;
    assign out_sample.data = sample_data[grant];

    always_comb begin
        for (int i = 0; i < N; i++) begin
            sample_ready[i] = out_ready && found && (grant == CH_W'(i));
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            last <= CH_W'(N - 1);
        end else if (out_valid && out_ready) begin
            last <= grant;
        end
    end

    assert property (@(posedge clock) disable iff (reset) $onehot0(sample_ready));

endmodule

// ==== design/dma_writer.sv ====
// Frame entries become 64-bit beats at consecutive addresses from base_address
// dma_done and rearm pulse together once the last beat has left the FIFO

`include "scope_macros.svh"

module dma_writer (
    input  logic clock,
    input  logic reset,
    input  scope_pkg::sample_t frame_sample,
    input  logic frame_valid,
    input  logic frame_last,
    output logic frame_ready,
    input  mem_pkg::addr_t base_address,
    output mem_pkg::write_beat_t mem_beat,
    output logic mem_valid,
    input  logic mem_ready,
    output logic rearm,
    output logic dma_done
);

    localparam int IDX_W = $clog2(`SCOPE_FRAME_DEPTH);

    mem_pkg::write_beat_t beat_q;
    logic beat_valid;
    logic beat_last;
    logic beat_ready;
    logic [IDX_W-1:0] frame_index;
    logic last_pending;
    logic take;

    // Beat register moves on whenever the FIFO takes its content
    assign frame_ready = !beat_valid || beat_ready;
    assign take = frame_valid && frame_ready;

    always_ff @(posedge clock) begin
        if (take) begin
            beat_q.addr <= base_address + (mem_pkg::addr_t'(frame_index) << 3);
            beat_q.data <= {16'(frame_sample.channel), 16'h0000, frame_sample.data};
            beat_last <= frame_last;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            beat_valid   <= 1'b0;
            frame_index  <= '0;
            last_pending <= 1'b0;
        end else begin
            if (take) begin
                beat_valid <= 1'b1;
                frame_index <= frame_last ? '0 : frame_index + 1'b1;
            end else if (beat_ready) begin
                beat_valid <= 1'b0;
            end
            if (beat_valid && beat_ready && beat_last) begin
                last_pending <= 1'b1;
            end else if (dma_done) begin
                last_pending <= 1'b0;
            end
        end
    end

    stream_fifo #(
        .payload_t(mem_pkg::write_beat_t),
        .DEPTH(`SCOPE_FIFO_DEPTH)
    ) beat_fifo (
        .clock(clock),
        .reset(reset),
        .in_data(beat_q),
        .in_valid(beat_valid),
        .in_ready(beat_ready),
        .out_data(mem_beat),
        .out_valid(mem_valid),
        .out_ready(mem_ready)
    );

    // FIFO empty after the last push means the last beat went out a cycle ago
    assign dma_done = last_pending && !mem_valid;
    assign rearm = dma_done;

    assert property (@(posedge clock) disable iff (reset) dma_done |=> !dma_done);

endmodule

// ==== design/mem_pkg.sv ====
// Memory-side types of the write port, byte addresses and 64-bit beats

package mem_pkg;

    typedef logic [31:0] addr_t;

    // Data layout of a beat
    //   63..48  channel tag, zero extended
    //   47..32  zero
    //   31..0   sample
    typedef struct packed {
        addr_t addr;
        logic [63:0] data;
    } write_beat_t;

endpackage

// ==== design/scope_capture.sv ====
// Capture engine top level, configuration is static while a frame is taken
// Single clock domain, single normal trigger per frame

`include "scope_macros.svh"

module scope_capture (
    input  logic clock,
    input  logic reset,
    input  logic [`SCOPE_SAMPLE_WIDTH-1:0] sample_data [`SCOPE_N_CHANNELS],
    input  logic [`SCOPE_N_CHANNELS-1:0] sample_valid,
    output logic [`SCOPE_N_CHANNELS-1:0] sample_ready,
    input  scope_pkg::trigger_cfg_t trigger,
    input  mem_pkg::addr_t base_address,
    output mem_pkg::write_beat_t mem_beat,
    output logic mem_valid,
    input  logic mem_ready,
    output logic dma_done
);

    scope_pkg::sample_t merged_sample;
    logic merged_valid;
    logic merged_ready;
    scope_pkg::sample_t buffered_sample;
    logic buffered_valid;
    logic buffered_ready;
    scope_pkg::sample_t frame_sample;
    logic frame_valid;
    logic frame_last;
    logic frame_ready;
    logic rearm;

    channel_arbiter arbiter (
        .clock(clock),
        .reset(reset),
        .sample_data(sample_data),
        .sample_valid(sample_valid),
        .sample_ready(sample_ready),
        .out_sample(merged_sample),
        .out_valid(merged_valid),
        .out_ready(merged_ready)
    );

    stream_fifo #(
        .payload_t(scope_pkg::sample_t),
        .DEPTH(`SCOPE_FIFO_DEPTH)
    ) sample_fifo (
        .clock(clock),
        .reset(reset),
        .in_data(merged_sample),
        .in_valid(merged_valid),
        .in_ready(merged_ready),
        .out_data(buffered_sample),
        .out_valid(buffered_valid),
        .out_ready(buffered_ready)
    );

    capture_buffer buffer (
        .clock(clock),
        .reset(reset),
        .in_sample(buffered_sample),
        .in_valid(buffered_valid),
        .in_ready(buffered_ready),
        .trigger(trigger),
        .frame_sample(frame_sample),
        .frame_valid(frame_valid),
        .frame_last(frame_last),
        .frame_ready(frame_ready),
        .rearm(rearm)
    );

    dma_writer writer (
        .clock(clock),
        .reset(reset),
        .frame_sample(frame_sample),
        .frame_valid(frame_valid),
        .frame_last(frame_last),
        .frame_ready(frame_ready),
        .base_address(base_address),
        .mem_beat(mem_beat),
        .mem_valid(mem_valid),
        .mem_ready(mem_ready),
        .rearm(rearm),
        .dma_done(dma_done)
    );

endmodule

// ==== design/scope_macros.svh ====
// Sizes of the capture engine. FRAME_DEPTH and FIFO_DEPTH must be powers of two
// and the trigger point field is sized from FRAME_DEPTH

`ifndef SCOPE_MACROS_SVH
`define SCOPE_MACROS_SVH

// Input streams and the tag that names them
`define SCOPE_N_CHANNELS 6
`define SCOPE_CHANNEL_BITS 3

`define SCOPE_SAMPLE_WIDTH 32

// One frame is one full turn of the circular buffer
`define SCOPE_FRAME_DEPTH 64

`define SCOPE_FIFO_DEPTH 4

`endif

// ==== design/scope_pkg.sv ====
// Sample-side types shared by the arbiter, capture buffer and DMA writer

`include "scope_macros.svh"

package scope_pkg;

    // Width of an index into one frame
    localparam int POINT_BITS = $clog2(`SCOPE_FRAME_DEPTH);

    // One sample tagged with the channel it came from
    typedef struct packed {
        logic [`SCOPE_CHANNEL_BITS-1:0] channel;
        logic [`SCOPE_SAMPLE_WIDTH-1:0] data;
    } sample_t;

    // Static trigger setup, point is the number of entries kept ahead of the trigger
    typedef struct packed {
        logic [`SCOPE_CHANNEL_BITS-1:0] channel;
        logic [`SCOPE_SAMPLE_WIDTH-1:0] level;
        logic [POINT_BITS-1:0] point;
    } trigger_cfg_t;

endpackage

// ==== design/stream_fifo.sv ====
// Register FIFO on valid/ready links, DEPTH must be a power of two
// Output valid follows an input transfer by one cycle

module stream_fifo #(
    parameter type payload_t = logic,
    parameter int DEPTH = 4
) (
    input  logic     clock,
    input  logic     reset,
    input  payload_t in_data,
    input  logic     in_valid,
    output logic     in_ready,
    output payload_t out_data,
    output logic     out_valid,
    input  logic     out_ready
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    payload_t storage [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0] count;
    logic push;
    logic pop;

    assign in_ready  = count != (PTR_W+1)'(DEPTH);
    assign out_valid = count != '0;
    assign out_data  = storage[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    always_ff @(posedge clock) begin
        if (push) begin
            storage[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    // A stalled head entry must not move or disappear
    assert property (@(posedge clock) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_data));

    // The occupancy never runs past the storage
    assert property (@(posedge clock) disable iff (reset) count <= (PTR_W+1)'(DEPTH));

endmodule

// ==== sim.f ====
+incdir+design
design/scope_pkg.sv
design/mem_pkg.sv
design/stream_fifo.sv
design/channel_arbiter.sv
design/capture_buffer.sv
design/dma_writer.sv
design/scope_capture.sv
tests/tb_clock.sv
tests/scope_capture_tb.sv

// ==== tests/scope_capture_tb.sv ====
// Two frames with different trigger setups, random valid and random mem_ready
// The ramps rely on round-robin fairness so channel 5 stays below its level at rearm

`include "scope_macros.svh"

module scope_capture_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int N = `SCOPE_N_CHANNELS;
    localparam int FRAME_DEPTH = `SCOPE_FRAME_DEPTH;
    localparam int FRAMES = 2;
    localparam int WATCHDOG_CYCLES = FRAMES * FRAME_DEPTH * 40;

    logic clock;
    logic reset;
    logic [31:0] sample_data [N] = '{default: '0};
    logic [N-1:0] sample_valid = '0;
    logic [N-1:0] sample_ready;
    scope_pkg::trigger_cfg_t trigger = frame_trigger(0);
    mem_pkg::addr_t base_address = frame_base(0);
    mem_pkg::write_beat_t mem_beat;
    logic mem_valid;
    logic mem_ready = 1'b0;
    logic dma_done;

    logic [31:0] rng = 32'd3;
    int ramp_count [N] = '{default: 0};
    mem_pkg::write_beat_t frame_store [FRAME_DEPTH];
    int beat_count = 0;
    int frames_done = 0;
    logic seen [N] = '{default: 1'b0};
    logic [31:0] last_value [N] = '{default: '0};
    int error_count = 0;
    int errors_at_start = 0;
    int tests_run = 0;
    int tests_failed = 0;

    // State of the previous edge, for the hold and pulse checks
    logic reset_q = 1'b0;
    logic done_q = 1'b0;
    logic beat_stalled = 1'b0;
    mem_pkg::write_beat_t held_beat;
    logic [N-1:0] chan_stalled = '0;
    logic [31:0] held_data [N];

    logic [15:0] beat_tag;
    logic [31:0] beat_value;
    logic [31:0] ramp_channel;
    logic prev_known;
    logic [31:0] expect_value;
    mem_pkg::addr_t expect_addr;

    tb_clock #(.PERIOD(4), .RESET_CYCLES(2)) clock_gen (.clock(clock), .reset(reset));

    scope_capture dut (
        .clock(clock),
        .reset(reset),
        .sample_data(sample_data),
        .sample_valid(sample_valid),
        .sample_ready(sample_ready),
        .trigger(trigger),
        .base_address(base_address),
        .mem_beat(mem_beat),
        .mem_valid(mem_valid),
        .mem_ready(mem_ready),
        .dma_done(dma_done)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function automatic logic [31:0] ramp_value(input int channel, input int count);
        return 32'(1000 * channel + count);
    endfunction

    function automatic scope_pkg::trigger_cfg_t frame_trigger(input int frame);
        scope_pkg::trigger_cfg_t cfg;
        cfg.channel = (frame == 0) ? 3'd2 : 3'd5;
        cfg.level = (frame == 0) ? 32'd2020 : 32'd5040;
        cfg.point = (frame == 0) ? 6'd16 : 6'd40;
        return cfg;
    endfunction

    function automatic mem_pkg::addr_t frame_base(input int frame);
        return (frame == 0) ? 32'h1000_0000 : 32'h2000_0800;
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] expected,
                                   input logic [63:0] actual);
        error_count++;
        $display("** Error at %0d ns: %s expected %0h, got %0h", $time, name, expected, actual);
    endtask

    task automatic report_failure(input string what);
        error_count++;
        $display("Check failed at %0d ns: %s", $time, what);
    endtask

    task automatic finish_test(input string name);
        int fresh;
        fresh = error_count - errors_at_start;
        tests_run++;
        if (fresh == 0) begin
            $display("%s: pass", name);
        end else begin
            tests_failed++;
            $display("%s: FAIL with %0d errors", name, fresh);
        end
        errors_at_start = error_count;
    endtask

    // The trigger beat is the ramp value just past level, its channel's previous beat is level
    task automatic check_trigger_beat();
        logic found;
        logic [31:0] prev;
        mem_pkg::write_beat_t hit;
        found = 1'b0;
        prev = '0;
        hit = frame_store[trigger.point];
        assert (hit.data[63:48] == 16'(trigger.channel))
            else report_mismatch("trigger beat channel", 64'(trigger.channel), 64'(hit.data[63:48]));
        assert (hit.data[31:0] == trigger.level + 1)
            else report_mismatch("trigger beat data", 64'(trigger.level + 1), 64'(hit.data[31:0]));
        for (int j = int'(trigger.point) - 1; j >= 0; j--) begin
            if (!found && frame_store[j].data[63:48] == 16'(trigger.channel)) begin
                found = 1'b1;
                prev = frame_store[j].data[31:0];
            end
        end
        assert (found) else report_failure("no sample of the trigger channel before the trigger");
        if (found) begin
            assert (prev == trigger.level)
                else report_mismatch("pre-trigger data", 64'(trigger.level), 64'(prev));
        end
    endtask

    always_comb begin
        beat_tag = mem_beat.data[63:48];
        beat_value = mem_beat.data[31:0];
        ramp_channel = beat_value / 1000;
        prev_known = 1'b0;
        expect_value = '0;
        if (beat_tag < 16'(N)) begin
            prev_known = seen[beat_tag[2:0]];
            expect_value = last_value[beat_tag[2:0]] + 1;
        end
        expect_addr = base_address + mem_pkg::addr_t'(8 * beat_count);
    end

    // Channel ramps and the memory sink share one random sequence
    always @(posedge clock) begin : drive_and_sink
        if (reset) begin
            sample_valid <= '0;
            mem_ready <= 1'b0;
            for (int i = 0; i < N; i++) begin
                ramp_count[i] <= 0;
                sample_data[i] <= ramp_value(i, 0);
            end
        end else begin
            for (int i = 0; i < N; i++) begin
                if (sample_valid[i] && sample_ready[i]) begin
                    ramp_count[i] <= ramp_count[i] + 1;
                    sample_data[i] <= ramp_value(i, ramp_count[i] + 1);
                end
                if (!sample_valid[i] || sample_ready[i]) begin
                    rng = xorshift(rng);
                    sample_valid[i] <= rng[1:0] != 2'b00;
                end
            end
            rng = xorshift(rng);
            mem_ready <= rng[3:2] != 2'b00;
            if (mem_valid && mem_ready && beat_count < FRAME_DEPTH) begin
                frame_store[beat_count] <= mem_beat;
                beat_count <= beat_count + 1;
                if (beat_tag < 16'(N)) begin
                    seen[beat_tag[2:0]] <= 1'b1;
                    last_value[beat_tag[2:0]] <= beat_value;
                end
            end
            if (dma_done) begin
                check_trigger_beat();
                beat_count <= 0;
                for (int i = 0; i < N; i++) begin
                    seen[i] <= 1'b0;
                end
                trigger <= frame_trigger(frames_done + 1);
                base_address <= frame_base(frames_done + 1);
                frames_done <= frames_done + 1;
            end
        end
    end

    always @(posedge clock) begin : history
        reset_q <= reset;
        done_q <= dma_done;
        beat_stalled <= mem_valid && !mem_ready;
        held_beat <= mem_beat;
        for (int i = 0; i < N; i++) begin
            chan_stalled[i] <= sample_valid[i] && !sample_ready[i];
            held_data[i] <= sample_data[i];
        end
    end

    assert property (@(posedge clock) reset_q |-> !mem_valid)
        else report_mismatch("mem_valid", 64'(0), 64'($sampled(mem_valid)));
    assert property (@(posedge clock) reset_q |-> !dma_done)
        else report_mismatch("dma_done", 64'(0), 64'($sampled(dma_done)));
    assert property (@(posedge clock) reset_q |-> sample_ready == '0)
        else report_mismatch("sample_ready", 64'(0), 64'($sampled(sample_ready)));

    assert property (@(posedge clock) disable iff (reset) beat_stalled |-> mem_valid)
        else report_mismatch("mem_valid", 64'(1), 64'($sampled(mem_valid)));
    assert property (@(posedge clock) disable iff (reset) beat_stalled |-> mem_beat == held_beat)
        else report_mismatch("mem_beat", 64'($sampled(held_beat.data)),
                             64'($sampled(mem_beat.data)));

    for (genvar g = 0; g < N; g++) begin : hold_checks
        assert property (@(posedge clock) disable iff (reset)
            chan_stalled[g] |-> sample_data[g] == held_data[g])
            else report_mismatch($sformatf("sample_data[%0d]", g), 64'($sampled(held_data[g])),
                                 64'($sampled(sample_data[g])));
    end

    assert property (@(posedge clock) disable iff (reset)
        mem_valid && mem_ready |-> mem_beat.addr == expect_addr)
        else report_mismatch("mem_beat.addr", 64'($sampled(expect_addr)),
                             64'($sampled(mem_beat.addr)));
    assert property (@(posedge clock) disable iff (reset)
        mem_valid && mem_ready |-> mem_beat.data[47:32] == 16'h0000)
        else report_mismatch("mem_beat.data[47:32]", 64'(0), 64'($sampled(mem_beat.data[47:32])));
    assert property (@(posedge clock) disable iff (reset)
        mem_valid && mem_ready |-> 32'(beat_tag) == ramp_channel)
        else report_mismatch("mem_beat channel tag", 64'($sampled(ramp_channel)),
                             64'($sampled(beat_tag)));
    assert property (@(posedge clock) disable iff (reset)
        mem_valid && mem_ready && prev_known |-> beat_value == expect_value)
        else report_mismatch("mem_beat sample", 64'($sampled(expect_value)),
                             64'($sampled(beat_value)));
    assert property (@(posedge clock) disable iff (reset)
        mem_valid && mem_ready |-> beat_count < FRAME_DEPTH)
        else report_failure("more beats than one frame arrived before dma_done");
    assert property (@(posedge clock) disable iff (reset) dma_done |-> beat_count == FRAME_DEPTH)
        else report_mismatch("beat count at dma_done", 64'(FRAME_DEPTH), 64'($sampled(beat_count)));
    assert property (@(posedge clock) disable iff (reset) done_q |-> !dma_done)
        else report_mismatch("dma_done", 64'(0), 64'($sampled(dma_done)));

    initial begin : sequence_control
        wait (reset === 1'b0);
        // Two edges so the last reset-state check has reported
        @(posedge clock);
        @(posedge clock);
        finish_test("reset state");
        for (int f = 1; f <= FRAMES; f++) begin
            wait (frames_done == f);
            // The pulse-length check of dma_done fires on the edge after the pulse
            @(posedge clock);
            @(posedge clock);
            finish_test($sformatf("frame %0d capture", f));
        end
        $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors",
                 tests_run, tests_run - tests_failed, tests_failed, error_count);
        if (tests_failed == 0 && error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("Timeout after %0d cycles with %0d of %0d frames written",
                 WATCHDOG_CYCLES, frames_done, FRAMES);
        $display("Test failed");
        $finish;
    end

endmodule

// ==== tests/tb_clock.sv ====
// Free-running clock and a synchronous reset held for RESET_CYCLES rising edges

module tb_clock #(
    parameter int PERIOD = 4,
    parameter int RESET_CYCLES = 2
) (
    output logic clock,
    output logic reset
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clock = 1'b0;
        forever #(PERIOD / 2) clock = ~clock;
    end

    // Released on a rising edge like every other testbench input
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        reset <= 1'b0;
    end

endmodule
